// File: hdl/msiptw_pkg.sv
// Shared widths, MSI PTE field positions, cause codes and state types
// Only the first 64 bits of an MSI PTE are described here
// Flat mode only, so MRIF entries have no field layout of their own
// Cause values follow the RISC-V IOMMU fault cause encoding

package msiptw_pkg;

    // Address and page number widths
    localparam int unsigned PLEN   = 56;
    localparam int unsigned PPN_W  = 44;
    localparam int unsigned GPLEN  = 41;
    localparam int unsigned GPPN_W = 29;

    // Memory read channel
    localparam int unsigned DATA_W      = 64;
    localparam int unsigned RESP_W      = 2;
    localparam int unsigned BURST_BEATS = 2;

    // Fault cause width
    localparam int unsigned CAUSE_W = 11;

    // Field positions in the first PTE beat
    localparam int unsigned PTE_V_BIT     = 0;
    localparam int unsigned PTE_M_LSB     = 1;
    localparam int unsigned PTE_RSV1_LSB  = 3;
    localparam int unsigned PTE_RSV1_MSB  = 9;
    localparam int unsigned PTE_PPN_LSB   = 10;
    localparam int unsigned PTE_RSV2_LSB  = 54;
    localparam int unsigned PTE_RSV2_MSB  = 62;
    localparam int unsigned PTE_C_BIT     = 63;

    // Read response okay
    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    // Walk FSM states
    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PROC_PTE,
        FAULT
    } walk_state_e;

    // PTE mode field, values 0 and 2 are reserved
    typedef enum logic [1:0] {
        MODE_MRIF = 2'd1,
        MODE_FLAT = 2'd3
    } pte_mode_e;

    // Fault causes reported on cause_o
    typedef enum logic [CAUSE_W-1:0] {
        CAUSE_NONE          = 11'd0,
        CAUSE_INSTR_ACCESS  = 11'd1,
        CAUSE_PTE_INVALID   = 11'd262,
        CAUSE_PTE_MISCONFIG = 11'd263,
        CAUSE_PT_CORRUPTION = 11'd270
    } cause_e;

endpackage

// File: hdl/msi_pte_addr_gen.sv
// MSI PTE address and guest page number registers
// Inputs are sampled only in the capture cycle, values appear one cycle later
// Outputs hold until the next capture, so the AR address stays stable
// Mask bits above the gathered file number width are simply ignored

module msi_pte_addr_gen (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 capture_i,
    input  logic                                 en_1s_i,
    input  logic [msiptw_pkg::GPLEN-1:0]         req_iova_i,
    input  logic [msiptw_pkg::GPPN_W-1:0]        gpte_ppn_i,
    input  logic [msiptw_pkg::PPN_W-1:0]         msiptp_ppn_i,
    input  logic [msiptw_pkg::GPPN_W-1:0]        msi_addr_mask_i,
    output logic [msiptw_pkg::PLEN-1:0]          pte_addr_o,
    output logic [msiptw_pkg::GPPN_W-1:0]        vpn_o
);

    localparam int unsigned PAD_W = msiptw_pkg::PLEN - msiptw_pkg::GPPN_W;

    logic [msiptw_pkg::GPPN_W-1:0] gpn;
    logic [msiptw_pkg::GPPN_W-1:0] file_num;
    logic [msiptw_pkg::PLEN-1:0]   pte_addr_d;
    logic [msiptw_pkg::PLEN-1:0]   pte_addr_q;
    logic [msiptw_pkg::GPPN_W-1:0] vpn_q;

    // Pack the masked page number bits into the low end, lowest bit first
    function automatic logic [msiptw_pkg::GPPN_W-1:0] gather_bits(
        input logic [msiptw_pkg::GPPN_W-1:0] value,
        input logic [msiptw_pkg::GPPN_W-1:0] mask
    );
        logic [msiptw_pkg::GPPN_W-1:0] result;
        int unsigned                   pos;
        result = '0;
        pos    = 0;
        for (int i = 0; i < msiptw_pkg::GPPN_W; i++) begin
            if (mask[i]) begin
                result[pos] = value[i];
                pos++;
            end
        end
        return result;
    endfunction

    // First stage gives a GPA page from the PTE, else the IOVA is already a GPA
    assign gpn = en_1s_i ? gpte_ppn_i : req_iova_i[msiptw_pkg::GPLEN-1:12];

    assign file_num = gather_bits(gpn, msi_addr_mask_i);

    // Table base plus 16 bytes per interrupt file entry
    assign pte_addr_d = {msiptp_ppn_i, 12'b0} | ({{PAD_W{1'b0}}, file_num} << 4);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pte_addr_q <= '0;
            vpn_q      <= '0;
        end else if (capture_i) begin
            pte_addr_q <= pte_addr_d;
            vpn_q      <= gpn;
        end
    end

    assign pte_addr_o = pte_addr_q;
    assign vpn_o      = vpn_q;

endmodule

// File: hdl/msi_pte_checker.sv
// Combinational check of the first MSI PTE beat
// Verdict is meaningful only in a cycle with a valid beat
// MRIF mode is not supported and is reported as misconfigured

module msi_pte_checker (
    input  logic [msiptw_pkg::DATA_W-1:0] r_data_i,
    input  logic [msiptw_pkg::RESP_W-1:0] r_resp_i,
    output logic                          pte_ok_o,
    output msiptw_pkg::cause_e            pte_cause_o
);

    logic                  pte_v;
    logic                  pte_c;
    logic                  rsv_set;
    msiptw_pkg::pte_mode_e pte_mode;

    // Field extraction
    assign pte_v    = r_data_i[msiptw_pkg::PTE_V_BIT];
    assign pte_c    = r_data_i[msiptw_pkg::PTE_C_BIT];
    assign pte_mode = msiptw_pkg::pte_mode_e'(
        r_data_i[msiptw_pkg::PTE_M_LSB +: $bits(msiptw_pkg::pte_mode_e)]);

    // Any reserved bit set in either field
    assign rsv_set =
        (|r_data_i[msiptw_pkg::PTE_RSV1_MSB:msiptw_pkg::PTE_RSV1_LSB]) ||
        (|r_data_i[msiptw_pkg::PTE_RSV2_MSB:msiptw_pkg::PTE_RSV2_LSB]);

    always_comb begin
        pte_ok_o    = 1'b0;
        pte_cause_o = msiptw_pkg::CAUSE_NONE;

        // Not valid, or custom format which is not handled
        if (!pte_v || pte_c) begin
            pte_cause_o = msiptw_pkg::CAUSE_PTE_INVALID;
        end else if (r_resp_i != msiptw_pkg::RESP_OKAY) begin
            // Bus error on the PTE fetch
            pte_cause_o = msiptw_pkg::CAUSE_PT_CORRUPTION;
        end else begin
            case (pte_mode)
                msiptw_pkg::MODE_FLAT: begin
                    // Flat entry, reserved fields must be zero
                    if (rsv_set) begin
                        pte_cause_o = msiptw_pkg::CAUSE_PTE_MISCONFIG;
                    end else begin
                        pte_ok_o = 1'b1;
                    end
                end
                // No MRIF support here
                msiptw_pkg::MODE_MRIF: begin
                    pte_cause_o = msiptw_pkg::CAUSE_PTE_MISCONFIG;
                end
                // Reserved modes
                default: begin
                    pte_cause_o = msiptw_pkg::CAUSE_PTE_MISCONFIG;
                end
            endcase
        end
    end

endmodule

// File: hdl/rd_burst_tracker.sv
// Tracks beats still owed by the current PTE read burst
// Assumes one burst in flight at a time, with last on the final beat
// A last beat always empties the tracker, even if the count disagrees

module rd_burst_tracker (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic ar_fire_i,
    input  logic r_valid_i,
    input  logic r_last_i,
    output logic burst_busy_o
);

    localparam int unsigned CNT_W = $clog2(msiptw_pkg::BURST_BEATS + 1);

    logic [CNT_W-1:0] beats_q;
    logic [CNT_W-1:0] beats_d;

    always_comb begin
        beats_d = beats_q;
        // Beat accounting
        if (r_valid_i && r_last_i) begin
            beats_d = '0;
        end else if (r_valid_i && (beats_q != '0)) begin
            beats_d = beats_q - 1'b1;
        end
        // New burst accepted
        if (ar_fire_i) begin
            beats_d = CNT_W'(msiptw_pkg::BURST_BEATS);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beats_q <= '0;
        end else begin
            beats_q <= beats_d;
        end
    end

    // Busy from AR handshake until the cycle after last
    assign burst_busy_o = (beats_q != '0);

endmodule

// File: hdl/msiptw_fsm.sv
// Walk FSM for flat MSI PTE fetches
// Triggers are ignored while active_o is high
// Verdict from the checker is taken only with the first read beat
// Fault state waits for the burst to drain before returning to idle

module msiptw_fsm (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               init_i,
    input  logic               is_rx_i,
    input  logic               mem_ar_ready_i,
    input  logic               mem_r_valid_i,
    input  logic               burst_busy_i,
    input  logic               pte_ok_i,
    input  msiptw_pkg::cause_e pte_cause_i,
    output logic               capture_o,
    output logic               mem_ar_valid_o,
    output logic               iotlb_update_o,
    output logic               active_o,
    output logic               error_o,
    output msiptw_pkg::cause_e cause_o
);

    msiptw_pkg::walk_state_e state_q;
    msiptw_pkg::walk_state_e state_d;
    msiptw_pkg::cause_e      cause_q;
    msiptw_pkg::cause_e      cause_d;
    logic                    trigger;

    // Busy while walking or while a burst is still draining
    assign active_o = (state_q != msiptw_pkg::IDLE) || burst_busy_i;

    // Accepted trigger
    assign trigger = init_i && !active_o;

    always_comb begin
        state_d        = state_q;
        cause_d        = cause_q;
        capture_o      = 1'b0;
        mem_ar_valid_o = 1'b0;
        iotlb_update_o = 1'b0;

        case (state_q)
            msiptw_pkg::IDLE: begin
                if (trigger) begin
                    // Read-for-execute to an MSI page is an access fault
                    if (is_rx_i) begin
                        cause_d = msiptw_pkg::CAUSE_INSTR_ACCESS;
                        state_d = msiptw_pkg::FAULT;
                    end else begin
                        capture_o = 1'b1;
                        state_d   = msiptw_pkg::MEM_ACCESS;
                    end
                end
            end

            // Hold the request until the memory takes it
            msiptw_pkg::MEM_ACCESS: begin
                mem_ar_valid_o = 1'b1;
                if (mem_ar_ready_i) begin
                    state_d = msiptw_pkg::PROC_PTE;
                end
            end

            // First beat decides, the second beat is left to the tracker
            msiptw_pkg::PROC_PTE: begin
                if (mem_r_valid_i) begin
                    if (pte_ok_i) begin
                        iotlb_update_o = 1'b1;
                        state_d        = msiptw_pkg::IDLE;
                    end else begin
                        cause_d = pte_cause_i;
                        state_d = msiptw_pkg::FAULT;
                    end
                end
            end

            // Report until the burst is gone, at least one cycle
            msiptw_pkg::FAULT: begin
                if (!burst_busy_i) begin
                    state_d = msiptw_pkg::IDLE;
                end
            end

            default: begin
                state_d = msiptw_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= msiptw_pkg::IDLE;
            cause_q <= msiptw_pkg::CAUSE_NONE;
        end else begin
            state_q <= state_d;
            cause_q <= cause_d;
        end
    end

    // Error and cause held for the whole fault state
    assign error_o = (state_q == msiptw_pkg::FAULT);
    assign cause_o = error_o ? cause_q : msiptw_pkg::CAUSE_NONE;

endmodule

// File: hdl/msiptw_top.sv
// MSI page table walker, flat mode only
// Read port has no ready, every beat is accepted when presented
// Each fetch is one two-beat burst, only the first beat is checked
// iotlb_pte_o mirrors the read data and is valid with iotlb_update_o

module msiptw_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // Walk request
    input  logic                          init_i,
    input  logic                          is_rx_i,
    input  logic                          en_1s_i,
    input  logic [msiptw_pkg::GPLEN-1:0]  req_iova_i,
    input  logic [msiptw_pkg::GPPN_W-1:0] gpte_ppn_i,
    input  logic [msiptw_pkg::PPN_W-1:0]  msiptp_ppn_i,
    input  logic [msiptw_pkg::GPPN_W-1:0] msi_addr_mask_i,
    // Memory read port
    output logic                          mem_ar_valid_o,
    output logic [msiptw_pkg::PLEN-1:0]   mem_ar_addr_o,
    input  logic                          mem_ar_ready_i,
    input  logic                          mem_r_valid_i,
    input  logic [msiptw_pkg::DATA_W-1:0] mem_r_data_i,
    input  logic [msiptw_pkg::RESP_W-1:0] mem_r_resp_i,
    input  logic                          mem_r_last_i,
    // Results
    output logic                          active_o,
    output logic                          iotlb_update_o,
    output logic [msiptw_pkg::DATA_W-1:0] iotlb_pte_o,
    output logic [msiptw_pkg::GPPN_W-1:0] vpn_o,
    output logic                          error_o,
    output msiptw_pkg::cause_e            cause_o
);

    logic               capture;
    logic               ar_fire;
    logic               burst_busy;
    logic               pte_ok;
    msiptw_pkg::cause_e pte_cause;

    // AR handshake strobe
    assign ar_fire = mem_ar_valid_o && mem_ar_ready_i;

    // Entry content goes straight to the IOTLB
    assign iotlb_pte_o = mem_r_data_i;

    msiptw_fsm msiptw_fsm_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_i         (init_i),
        .is_rx_i        (is_rx_i),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_r_valid_i  (mem_r_valid_i),
        .burst_busy_i   (burst_busy),
        .pte_ok_i       (pte_ok),
        .pte_cause_i    (pte_cause),
        .capture_o      (capture),
        .mem_ar_valid_o (mem_ar_valid_o),
        .iotlb_update_o (iotlb_update_o),
        .active_o       (active_o),
        .error_o        (error_o),
        .cause_o        (cause_o)
    );

    msi_pte_addr_gen msi_pte_addr_gen_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .capture_i       (capture),
        .en_1s_i         (en_1s_i),
        .req_iova_i      (req_iova_i),
        .gpte_ppn_i      (gpte_ppn_i),
        .msiptp_ppn_i    (msiptp_ppn_i),
        .msi_addr_mask_i (msi_addr_mask_i),
        .pte_addr_o      (mem_ar_addr_o),
        .vpn_o           (vpn_o)
    );

    msi_pte_checker msi_pte_checker_inst (
        .r_data_i    (mem_r_data_i),
        .r_resp_i    (mem_r_resp_i),
        .pte_ok_o    (pte_ok),
        .pte_cause_o (pte_cause)
    );

    rd_burst_tracker rd_burst_tracker_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ar_fire_i    (ar_fire),
        .r_valid_i    (mem_r_valid_i),
        .r_last_i     (mem_r_last_i),
        .burst_busy_o (burst_busy)
    );

endmodule

// File: verification/msiptw_assertions.sv
// Concurrent checks on the walk FSM outputs, bound to every msiptw_fsm
// Disabled while reset is asserted
// fail_count is read by the testbench at the end of the run

module msiptw_assertions (
    input logic clk_i,
    input logic rst_ni,
    input logic mem_ar_valid_o,
    input logic mem_ar_ready_i,
    input logic iotlb_update_o,
    input logic error_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // AR request held until the memory takes it
    ar_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_ar_valid_o && !mem_ar_ready_i) |=> mem_ar_valid_o)
    else begin
        $error("AR valid dropped before ready");
        fail_count++;
    end

    // A walk ends in an update or in an error, never both
    update_error_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(iotlb_update_o && error_o))
    else begin
        $error("IOTLB update and error high in the same cycle");
        fail_count++;
    end

    // Update is a single cycle pulse
    update_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        iotlb_update_o |=> !iotlb_update_o)
    else begin
        $error("IOTLB update longer than one cycle");
        fail_count++;
    end

endmodule

bind msiptw_fsm msiptw_assertions msiptw_assertions_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .iotlb_update_o (iotlb_update_o),
    .error_o        (error_o)
);

// File: verification/msiptw_tb.sv
// Random testbench for the flat mode MSI page table walker
// Plays the memory side with one burst in flight and random ready and beat gaps
// Address, vpn and verdict are predicted by a model kept in this file
// Inputs change 2 ns after the rising edge, outputs are sampled at the falling edge

module msiptw_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned TIMEOUT = 200;
    localparam int unsigned N_WALKS = 300;

    logic                          clk_i;
    logic                          rst_ni;
    logic                          init;
    logic                          is_rx;
    logic                          en_1s;
    logic [msiptw_pkg::GPLEN-1:0]  req_iova;
    logic [msiptw_pkg::GPPN_W-1:0] gpte_ppn;
    logic [msiptw_pkg::PPN_W-1:0]  msiptp_ppn;
    logic [msiptw_pkg::GPPN_W-1:0] msi_addr_mask;
    logic                          mem_ar_valid;
    logic [msiptw_pkg::PLEN-1:0]   mem_ar_addr;
    logic                          mem_ar_ready;
    logic                          mem_r_valid;
    logic [msiptw_pkg::DATA_W-1:0] mem_r_data;
    logic [msiptw_pkg::RESP_W-1:0] mem_r_resp;
    logic                          mem_r_last;
    logic                          active;
    logic                          iotlb_update;
    logic [msiptw_pkg::DATA_W-1:0] iotlb_pte;
    logic [msiptw_pkg::GPPN_W-1:0] vpn;
    logic                          err;
    msiptw_pkg::cause_e            cause;

    int unsigned mismatches = 0;
    int unsigned failures   = 0;
    logic        timed_out  = 1'b0;

    msiptw_top msiptw_top_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .init_i          (init),
        .is_rx_i         (is_rx),
        .en_1s_i         (en_1s),
        .req_iova_i      (req_iova),
        .gpte_ppn_i      (gpte_ppn),
        .msiptp_ppn_i    (msiptp_ppn),
        .msi_addr_mask_i (msi_addr_mask),
        .mem_ar_valid_o  (mem_ar_valid),
        .mem_ar_addr_o   (mem_ar_addr),
        .mem_ar_ready_i  (mem_ar_ready),
        .mem_r_valid_i   (mem_r_valid),
        .mem_r_data_i    (mem_r_data),
        .mem_r_resp_i    (mem_r_resp),
        .mem_r_last_i    (mem_r_last),
        .active_o        (active),
        .iotlb_update_o  (iotlb_update),
        .iotlb_pte_o     (iotlb_pte),
        .vpn_o           (vpn),
        .error_o         (err),
        .cause_o         (cause)
    );

    // 40 ns clock
    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    task automatic drive_edge();
        @(posedge clk_i);
        #2;
    endtask

    task automatic sample_edge();
        @(negedge clk_i);
    endtask

    task automatic check_addr(input logic [msiptw_pkg::PLEN-1:0] got,
                              input logic [msiptw_pkg::PLEN-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: mem_ar_addr_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_vpn(input logic [msiptw_pkg::GPPN_W-1:0] got,
                             input logic [msiptw_pkg::GPPN_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: vpn_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_pte(input logic [msiptw_pkg::DATA_W-1:0] got,
                             input logic [msiptw_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: iotlb_pte_o got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_cause(input msiptw_pkg::cause_e got, input msiptw_pkg::cause_e exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: cause_o got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("error at %0t: %s", $time, msg);
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    // Scan the mask from the top and shift each selected bit in at bit 0
    function automatic logic [msiptw_pkg::GPPN_W-1:0] model_file_num(
        input logic [msiptw_pkg::GPPN_W-1:0] gpn,
        input logic [msiptw_pkg::GPPN_W-1:0] mask
    );
        logic [msiptw_pkg::GPPN_W-1:0] file_bits;
        file_bits = '0;
        for (int b = msiptw_pkg::GPPN_W - 1; b >= 0; b--) begin
            if (mask[b]) begin
                file_bits = {file_bits[msiptw_pkg::GPPN_W-2:0], gpn[b]};
            end
        end
        return file_bits;
    endfunction

    // Table base page OR 16-byte entry offset
    function automatic logic [msiptw_pkg::PLEN-1:0] model_addr(
        input logic [msiptw_pkg::PPN_W-1:0]  ppn,
        input logic [msiptw_pkg::GPPN_W-1:0] file_num
    );
        logic [msiptw_pkg::PLEN-1:0] base;
        logic [msiptw_pkg::PLEN-1:0] offset;
        base                                = '0;
        base[msiptw_pkg::PLEN-1:12]         = ppn;
        offset                              = '0;
        offset[msiptw_pkg::GPPN_W+3:4]      = file_num;
        return base | offset;
    endfunction

    // Verdict in priority order: V and C, response, mode, reserved bits
    function automatic msiptw_pkg::cause_e model_cause(input logic [63:0] pte,
                                                       input logic [1:0]  resp);
        if (!pte[0] || pte[63]) begin
            return msiptw_pkg::CAUSE_PTE_INVALID;
        end
        if (resp != 2'b00) begin
            return msiptw_pkg::CAUSE_PT_CORRUPTION;
        end
        if (pte[2:1] != 2'b11) begin
            return msiptw_pkg::CAUSE_PTE_MISCONFIG;
        end
        if ((|pte[9:3]) || (|pte[62:54])) begin
            return msiptw_pkg::CAUSE_PTE_MISCONFIG;
        end
        return msiptw_pkg::CAUSE_NONE;
    endfunction

    // Kinds 0..4 valid flat, then one fault flavour each, 10 fully random
    function automatic logic [63:0] make_entry(input int unsigned kind);
        logic [63:0] pte;
        logic [63:0] r;
        r          = rand64();
        pte        = '0;
        pte[0]     = 1'b1;
        pte[2:1]   = 2'b11;
        pte[53:10] = r[43:0];
        case (kind)
            5: pte[0] = 1'b0;
            6: pte[63] = 1'b1;
            7: pte[2:1] = 2'b01;
            8: pte[2:1] = {r[50], 1'b0};
            9: begin
                if (r[51]) begin
                    pte[9:3] = r[62:56] | 7'h01;
                end else begin
                    pte[62:54] = r[63:55] | 9'h001;
                end
            end
            10: pte = r;
            default: ;
        endcase
        return pte;
    endfunction

    task automatic randomize_request();
        logic [63:0] r;
        r          = rand64();
        req_iova   = r[msiptw_pkg::GPLEN-1:0];
        r          = rand64();
        msiptp_ppn = r[43:0];
        gpte_ppn   = r[63:35];
        r          = rand64();
        en_1s      = r[0];
        // Empty, full or sparse MSI address mask
        case (r[2:1])
            2'd0:    msi_addr_mask = '0;
            2'd1:    msi_addr_mask = '1;
            2'd2:    msi_addr_mask = r[40:12] & r[63:35];
            default: msi_addr_mask = r[40:12];
        endcase
    endtask

    // Triggers while busy must be ignored
    task automatic drive_noise();
        init  = ($urandom_range(0, 1) == 1);
        is_rx = ($urandom_range(0, 1) == 1);
        randomize_request();
    endtask

    task automatic note_outcome(inout int unsigned updates, inout int unsigned errors,
                                inout logic prev_err, input msiptw_pkg::cause_e exp_cause);
        if (iotlb_update) begin
            updates++;
        end
        if (err && !prev_err) begin
            errors++;
        end
        if (err) begin
            check_cause(cause, exp_cause);
        end
        prev_err = err;
    endtask

    task automatic run_rx_walk();
        int unsigned cycles;
        int unsigned updates;
        int unsigned errors;
        logic        prev_err;
        updates  = 0;
        errors   = 0;
        prev_err = 1'b0;
        cycles   = 0;
        drive_edge();
        randomize_request();
        init  = 1'b1;
        is_rx = 1'b1;
        sample_edge();
        note_outcome(updates, errors, prev_err, msiptw_pkg::CAUSE_INSTR_ACCESS);
        do begin
            drive_edge();
            init  = 1'b0;
            is_rx = 1'b0;
            sample_edge();
            note_outcome(updates, errors, prev_err, msiptw_pkg::CAUSE_INSTR_ACCESS);
            check_flag("mem_ar_valid_o", mem_ar_valid, 1'b0);
            cycles++;
        end while (active && cycles < TIMEOUT);
        if (active) begin
            report_failure("timeout waiting for the walker to leave the fault state");
            timed_out = 1'b1;
            return;
        end
        if (cycles != 2) begin
            report_failure($sformatf("read-for-execute fault took %0d cycles, expected 2",
                                     cycles));
        end
        if (updates != 0 || errors != 1) begin
            report_failure("read-for-execute did not end in exactly one error");
        end
    endtask

    task automatic run_mem_walk();
        logic [msiptw_pkg::GPPN_W-1:0] exp_vpn;
        logic [msiptw_pkg::PLEN-1:0]   exp_addr;
        logic [63:0]                   entry;
        logic [63:0]                   r;
        logic [1:0]                    resp;
        msiptw_pkg::cause_e            exp_cause;
        int unsigned                   ready_delay;
        int unsigned                   gap;
        int unsigned                   cycles;
        int unsigned                   updates;
        int unsigned                   errors;
        logic                          prev_err;
        logic                          fired;
        updates  = 0;
        errors   = 0;
        prev_err = 1'b0;
        fired    = 1'b0;
        cycles   = 0;

        drive_edge();
        randomize_request();
        init      = 1'b1;
        is_rx     = 1'b0;
        // Model the request as presented in the trigger cycle
        exp_vpn   = en_1s ? gpte_ppn : req_iova[msiptw_pkg::GPLEN-1:12];
        exp_addr  = model_addr(msiptp_ppn, model_file_num(exp_vpn, msi_addr_mask));
        entry     = make_entry($urandom_range(0, 10));
        r         = rand64();
        resp      = ($urandom_range(0, 5) == 0) ? r[1:0] : 2'b00;
        exp_cause = model_cause(entry, resp);
        ready_delay = $urandom_range(0, 3);
        sample_edge();
        check_flag("mem_ar_valid_o", mem_ar_valid, 1'b0);

        // AR phase with back-pressure
        while (!fired && cycles < TIMEOUT) begin
            drive_edge();
            drive_noise();
            mem_ar_ready = (cycles >= ready_delay);
            sample_edge();
            check_flag("active_o", active, 1'b1);
            // Request rises the cycle after the trigger and holds until taken
            check_flag("mem_ar_valid_o", mem_ar_valid, 1'b1);
            note_outcome(updates, errors, prev_err, exp_cause);
            if (mem_ar_valid) begin
                check_addr(mem_ar_addr, exp_addr);
                check_vpn(vpn, exp_vpn);
                fired = mem_ar_ready;
            end
            cycles++;
        end
        if (!fired) begin
            report_failure("timeout waiting for the AR handshake");
            timed_out = 1'b1;
            return;
        end

        // Two beats after random gaps, first beat is the entry
        for (int beat = 0; beat < msiptw_pkg::BURST_BEATS; beat++) begin
            gap = $urandom_range(0, 3);
            for (int g = 0; g <= gap; g++) begin
                drive_edge();
                drive_noise();
                mem_ar_ready = 1'b0;
                r            = rand64();
                mem_r_valid  = (g == gap);
                mem_r_last   = (g == gap) && (beat == msiptw_pkg::BURST_BEATS - 1);
                mem_r_data   = (beat == 0) ? entry : r;
                mem_r_resp   = (beat == 0) ? resp : r[1:0];
                sample_edge();
                check_flag("active_o", active, 1'b1);
                check_flag("mem_ar_valid_o", mem_ar_valid, 1'b0);
                note_outcome(updates, errors, prev_err, exp_cause);
                if (mem_r_valid && beat == 0) begin
                    check_flag("iotlb_update_o", iotlb_update,
                               exp_cause == msiptw_pkg::CAUSE_NONE);
                    if (iotlb_update) begin
                        check_pte(iotlb_pte, entry);
                    end
                end
            end
        end

        // Drain until idle, fault state outlasts the burst by one cycle
        cycles = 0;
        do begin
            drive_edge();
            init        = 1'b0;
            is_rx       = 1'b0;
            mem_r_valid = 1'b0;
            mem_r_last  = 1'b0;
            sample_edge();
            check_flag("mem_ar_valid_o", mem_ar_valid, 1'b0);
            note_outcome(updates, errors, prev_err, exp_cause);
            cycles++;
        end while (active && cycles < TIMEOUT);
        if (active) begin
            report_failure("timeout waiting for active_o to fall after the last beat");
            timed_out = 1'b1;
            return;
        end
        if (cycles != ((exp_cause == msiptw_pkg::CAUSE_NONE) ? 1 : 2)) begin
            report_failure($sformatf("walker idle %0d cycles after the last beat", cycles));
        end
        if (exp_cause == msiptw_pkg::CAUSE_NONE && (updates != 1 || errors != 0)) begin
            report_failure("valid flat entry did not give exactly one IOTLB update");
        end
        if (exp_cause != msiptw_pkg::CAUSE_NONE && (updates != 0 || errors != 1)) begin
            report_failure("faulting entry did not give exactly one error");
        end
        // No trigger may have been captured during the walk
        check_vpn(vpn, exp_vpn);
    endtask

    initial begin
        void'($urandom(32'h8b25_e487));
        rst_ni        = 1'b0;
        init          = 1'b0;
        is_rx         = 1'b0;
        en_1s         = 1'b0;
        req_iova      = '0;
        gpte_ppn      = '0;
        msiptp_ppn    = '0;
        msi_addr_mask = '0;
        mem_ar_ready  = 1'b0;
        mem_r_valid   = 1'b0;
        mem_r_data    = '0;
        mem_r_resp    = '0;
        mem_r_last    = 1'b0;

        repeat (2) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        sample_edge();
        check_flag("active_o", active, 1'b0);
        check_flag("error_o", err, 1'b0);
        check_flag("iotlb_update_o", iotlb_update, 1'b0);
        check_flag("mem_ar_valid_o", mem_ar_valid, 1'b0);

        for (int n = 0; n < N_WALKS; n++) begin
            if ($urandom_range(0, 7) == 0) begin
                run_rx_walk();
            end else begin
                run_mem_walk();
            end
            if (timed_out) begin
                break;
            end
            // Some walks start right away, others after idle cycles
            repeat ($urandom_range(0, 2)) begin
                drive_edge();
            end
        end

        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures,
                 msiptw_top_inst.msiptw_fsm_inst.msiptw_assertions_inst.fail_count);
        if (mismatches == 0 && failures == 0 &&
            msiptw_top_inst.msiptw_fsm_inst.msiptw_assertions_inst.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/msiptw_pkg.sv
hdl/msi_pte_addr_gen.sv
hdl/msi_pte_checker.sv
hdl/rd_burst_tracker.sv
hdl/msiptw_fsm.sv
hdl/msiptw_top.sv
verification/msiptw_assertions.sv
verification/msiptw_tb.sv
